// ==== ex_stage.f ====
source/ex_pkg.sv
source/div_alu_if.sv
source/ex_alu.sv
source/ex_mult.sv
source/ex_div.sv
source/ex_stage.sv
bench/ex_stage_chk.sv
bench/ex_stage_tb.sv

// ==== Bender.yml ====
package:
  name: ex_stage

sources:
  # Design, in compile order
  - files:
      - source/ex_pkg.sv
      - source/div_alu_if.sv
      - source/ex_alu.sv
      - source/ex_mult.sv
      - source/ex_div.sv
      - source/ex_stage.sv

  # Simulation only
  - target: test
    files:
      - bench/ex_stage_chk.sv
      - bench/ex_stage_tb.sv

// ==== bench/ex_stage_testdata.txt ====
# unit(0 alu 1 mul 2 div) op a b branch rf_we waddr kill halt exp_data exp_branch, all hex
# kill 0 runs normally, n>0 raises kill_i after n-1 cycles; halt is cycles held at the start
0 0 00000005 00000007 0 1 01 0 0 0000000c 0
0 1 00000003 00000005 0 1 02 0 0 fffffffe 0
0 2 f0f0ff00 0ff00ff0 0 1 03 0 0 00f00f00 0
0 3 f0000001 0000f000 0 1 04 0 0 f000f001 0
0 4 aaaa5555 ffff0000 0 1 05 0 0 55555555 0
0 5 00000003 00000024 0 1 06 0 0 00000030 0
0 6 80000000 0000001f 0 1 07 0 0 00000001 0
0 7 80000010 00000004 0 1 08 0 2 f8000001 0
0 8 fffffffe 00000001 0 1 09 0 0 00000001 0
0 9 fffffffe 00000001 0 1 0a 0 0 00000000 0
0 0 12345678 11111111 0 0 0b 0 0 23456789 0
0 a 00000042 00000042 1 0 00 0 0 00000000 1
0 b 00000042 00000042 1 0 00 0 0 00000000 0
0 c ffffffff 00000001 1 0 00 0 0 00000000 1
0 d ffffffff 00000001 1 0 00 0 0 00000000 0
0 e ffffffff 00000001 1 0 00 0 0 00000000 0
0 f ffffffff 00000001 1 0 00 0 0 00000000 1
1 0 00001234 00005678 0 1 0c 0 0 06260060 0
1 1 ffffffff 00000002 0 1 0d 0 0 ffffffff 0
1 1 80000000 80000000 0 1 0e 0 3 40000000 0
1 2 ffffffff ffffffff 0 1 0f 0 0 ffffffff 0
1 3 ffffffff ffffffff 0 1 10 0 0 fffffffe 0
2 0 fffffff9 00000002 0 1 11 0 0 fffffffd 0
2 1 00000064 00000007 0 1 12 0 0 0000000e 0
2 2 fffffff9 00000002 0 1 13 0 0 ffffffff 0
2 3 00000064 00000007 0 1 14 0 0 00000002 0
2 2 00000007 fffffffe 0 1 15 0 0 00000001 0
2 0 00000064 fffffff9 0 1 16 0 0 fffffff2 0
2 0 00001234 00000000 0 1 17 0 0 ffffffff 0
2 1 80000000 00000000 0 1 18 0 0 ffffffff 0
2 2 fffffff9 00000000 0 1 19 0 0 fffffff9 0
2 3 00000055 00000000 0 1 1a 0 0 00000055 0
2 0 80000000 ffffffff 0 1 1b 0 0 80000000 0
2 2 80000000 ffffffff 0 1 1c 0 0 00000000 0
2 1 ffffffff 00000010 0 1 1d 0 2 0fffffff 0
2 3 fffffffe 80000000 0 1 1e 0 0 7ffffffe 0
2 0 00001000 00000001 0 1 1f 5 0 00000000 0
0 0 00000001 00000001 0 1 1f 1 0 00000000 0
1 0 00000003 00000003 0 1 1f 2 0 00000000 0
0 4 0000ffff 00000f0f 0 1 1f 0 0 0000f0f0 0

// ==== bench/ex_stage_tb.sv ====
// Testbench for the execute stage; replays bench/ex_stage_testdata.txt and checks write-back
`default_nettype none

module ex_stage_tb import ex_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  // One line of the test data
  typedef struct {
    logic [1:0]            unit;
    logic [3:0]            op;
    logic [XLEN-1:0]       a;
    logic [XLEN-1:0]       b;
    logic                  branch;
    logic                  rf_we;
    logic [REG_ADDR_W-1:0] waddr;
    int unsigned           kill;
    int unsigned           halt;
    logic [XLEN-1:0]       exp_data;
    logic                  exp_bd;
  } vector_t;

  logic                  clk;
  logic                  rst_n;
  logic                  valid_i;
  logic                  alu_en_i;
  logic                  mul_en_i;
  logic                  div_en_i;
  alu_op_e               alu_op_i;
  mul_op_e               mul_op_i;
  div_op_e               div_op_i;
  logic [XLEN-1:0]       operand_a_i;
  logic [XLEN-1:0]       operand_b_i;
  logic                  branch_i;
  logic                  rf_we_i;
  logic [REG_ADDR_W-1:0] rf_waddr_i;
  logic                  kill_i;
  logic                  halt_i;
  logic                  wb_ready_i;
  logic                  ex_ready_o;
  logic                  ex_valid_o;
  logic                  branch_decision_o;
  logic                  wb_valid_o;
  logic                  wb_rf_we_o;
  logic [REG_ADDR_W-1:0] wb_rf_waddr_o;
  logic [XLEN-1:0]       wb_rf_wdata_o;
  logic                  wb_bch_taken_o;

  vector_t vecs[$];

  ex_stage u_ex_stage (
    .clk               (clk),
    .rst_n             (rst_n),
    .valid_i           (valid_i),
    .alu_en_i          (alu_en_i),
    .mul_en_i          (mul_en_i),
    .div_en_i          (div_en_i),
    .alu_op_i          (alu_op_i),
    .mul_op_i          (mul_op_i),
    .div_op_i          (div_op_i),
    .operand_a_i       (operand_a_i),
    .operand_b_i       (operand_b_i),
    .branch_i          (branch_i),
    .rf_we_i           (rf_we_i),
    .rf_waddr_i        (rf_waddr_i),
    .kill_i            (kill_i),
    .halt_i            (halt_i),
    .wb_ready_i        (wb_ready_i),
    .ex_ready_o        (ex_ready_o),
    .ex_valid_o        (ex_valid_o),
    .branch_decision_o (branch_decision_o),
    .wb_valid_o        (wb_valid_o),
    .wb_rf_we_o        (wb_rf_we_o),
    .wb_rf_waddr_o     (wb_rf_waddr_o),
    .wb_rf_wdata_o     (wb_rf_wdata_o),
    .wb_bch_taken_o    (wb_bch_taken_o)
  );

  bind ex_stage ex_stage_chk u_chk (
    .clk            (clk),
    .rst_n          (rst_n),
    .valid_i        (valid_i),
    .alu_en_i       (alu_en_i),
    .mul_en_i       (mul_en_i),
    .div_en_i       (div_en_i),
    .kill_i         (kill_i),
    .halt_i         (halt_i),
    .wb_ready_i     (wb_ready_i),
    .ex_valid_o     (ex_valid_o),
    .wb_valid_o     (wb_valid_o),
    .wb_rf_we_o     (wb_rf_we_o),
    .wb_rf_waddr_o  (wb_rf_waddr_o),
    .wb_rf_wdata_o  (wb_rf_wdata_o),
    .wb_bch_taken_o (wb_bch_taken_o)
  );

  // 8 ns clock
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Failure reporting and compares
  //////////////////////////////////////////////////////////////////////

  task automatic end_with_failure();
    $display("TEST FAIL");
    $fatal(1, "stopping after the first error");
  endtask

  task automatic abort_run(input string why);
    $display("%0t ns: %s", $time, why);
    end_with_failure();
  endtask

  task automatic compare_word(input string name, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] want);
    if (got !== want) begin
      $display("ERR %0t ns %s got %h expected %h", $time, name, got, want);
      end_with_failure();
    end
  endtask

  task automatic compare_addr(input string name, input logic [REG_ADDR_W-1:0] got,
                              input logic [REG_ADDR_W-1:0] want);
    if (got !== want) begin
      $display("ERR %0t ns %s got %h expected %h", $time, name, got, want);
      end_with_failure();
    end
  endtask

  task automatic compare_flag(input string name, input logic got, input logic want);
    if (got !== want) begin
      $display("ERR %0t ns %s got %b expected %b", $time, name, got, want);
      end_with_failure();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic load_vectors();
    int          fd;
    int          n;
    string       line;
    logic [31:0] f [11];
    vector_t     v;
    fd = $fopen("bench/ex_stage_testdata.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open bench/ex_stage_testdata.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        // Skip blank and comment lines
        if (line.len() < 2 || line[0] == "#") begin
          continue;
        end
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2], f[3],
                    f[4], f[5], f[6], f[7], f[8], f[9], f[10]);
        if (n != 11) begin
          abort_run({"malformed line in test data: ", line});
        end else begin
          v.unit     = f[0][1:0];
          v.op       = f[1][3:0];
          v.a        = f[2];
          v.b        = f[3];
          v.branch   = f[4][0];
          v.rf_we    = f[5][0];
          v.waddr    = f[6][REG_ADDR_W-1:0];
          v.kill     = f[7];
          v.halt     = f[8];
          v.exp_data = f[9];
          v.exp_bd   = f[10][0];
          vecs.push_back(v);
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic idle_inputs();
    valid_i     = 1'b0;
    alu_en_i    = 1'b0;
    mul_en_i    = 1'b0;
    div_en_i    = 1'b0;
    alu_op_i    = ADD;
    mul_op_i    = MUL;
    div_op_i    = DIV;
    operand_a_i = '0;
    operand_b_i = '0;
    branch_i    = 1'b0;
    rf_we_i     = 1'b0;
    rf_waddr_i  = '0;
    kill_i      = 1'b0;
    halt_i      = 1'b0;
  endtask

  task automatic drive_instr(input vector_t v);
    valid_i     = 1'b1;
    alu_en_i    = (v.unit == 2'd0);
    mul_en_i    = (v.unit == 2'd1);
    div_en_i    = (v.unit == 2'd2);
    alu_op_i    = alu_op_e'(v.op);
    mul_op_i    = mul_op_e'(v.op[1:0]);
    div_op_i    = div_op_e'(v.op[1:0]);
    operand_a_i = v.a;
    operand_b_i = v.b;
    branch_i    = v.branch;
    rf_we_i     = v.rf_we;
    rf_waddr_i  = v.waddr;
  endtask

  // Present one instruction until its accepting edge, or until it is killed
  task automatic run_instr(input vector_t v, input int idx);
    int unsigned           gap;
    int unsigned           cyc;
    bit                    done;
    bit                    accept;
    bit                    stalled;
    logic                  hold_valid;
    logic                  hold_we;
    logic                  hold_bch;
    logic [REG_ADDR_W-1:0] hold_addr;
    logic [XLEN-1:0]       hold_data;
    gap = $urandom % 3;
    idle_inputs();
    repeat (gap) begin
      wb_ready_i = (($urandom % 4) != 0);
      @(posedge clk);
      #1;
    end
    drive_instr(v);
    cyc  = 0;
    done = 1'b0;
    while (!done) begin
      halt_i     = (cyc < v.halt);
      kill_i     = (v.kill != 0) && (cyc == v.kill - 1);
      // Killed lines run unstalled so every edge is a bubble
      wb_ready_i = (v.kill != 0) || (($urandom % 4) != 0);
      @(negedge clk);
      accept     = ex_valid_o && wb_ready_i;
      stalled    = !wb_ready_i;
      hold_valid = wb_valid_o;
      hold_we    = wb_rf_we_o;
      hold_bch   = wb_bch_taken_o;
      hold_addr  = wb_rf_waddr_o;
      hold_data  = wb_rf_wdata_o;
      if (halt_i && !kill_i) begin
        compare_flag("ex_valid_o", ex_valid_o, 1'b0);
        compare_flag("ex_ready_o", ex_ready_o, 1'b0);
      end
      if (kill_i) begin
        compare_flag("ex_valid_o", ex_valid_o, 1'b0);
        compare_flag("ex_ready_o", ex_ready_o, 1'b1);
      end
      if (stalled) begin
        compare_flag("ex_ready_o", ex_ready_o, 1'b0);
      end
      // In the first unhalted cycle the ALU answers at once and the multiplier later
      if (cyc == v.halt && !kill_i) begin
        if (v.unit == 2'd0) begin
          compare_flag("ex_valid_o", ex_valid_o, 1'b1);
        end
        if (v.unit == 2'd1) begin
          compare_flag("ex_valid_o", ex_valid_o, 1'b0);
        end
      end
      if (accept) begin
        if (v.kill != 0) begin
          abort_run($sformatf("killed vector %0d reached write-back", idx));
        end else begin
          compare_flag("branch_decision_o", branch_decision_o, v.exp_bd);
          // Every unit is ready on the accepting edge
          compare_flag("ex_ready_o", ex_ready_o, 1'b1);
        end
      end
      @(posedge clk);
      #1;
      if (stalled) begin
        compare_flag("wb_valid_o", wb_valid_o, hold_valid);
        compare_flag("wb_rf_we_o", wb_rf_we_o, hold_we);
        compare_flag("wb_bch_taken_o", wb_bch_taken_o, hold_bch);
        compare_addr("wb_rf_waddr_o", wb_rf_waddr_o, hold_addr);
        compare_word("wb_rf_wdata_o", wb_rf_wdata_o, hold_data);
      end
      if (v.kill != 0) begin
        compare_flag("wb_valid_o", wb_valid_o, 1'b0);
      end
      if (accept) begin
        compare_flag("wb_valid_o", wb_valid_o, 1'b1);
        compare_flag("wb_rf_we_o", wb_rf_we_o, v.rf_we);
        compare_flag("wb_bch_taken_o", wb_bch_taken_o, v.exp_bd);
        if (v.rf_we) begin
          compare_addr("wb_rf_waddr_o", wb_rf_waddr_o, v.waddr);
          compare_word("wb_rf_wdata_o", wb_rf_wdata_o, v.exp_data);
        end
        done = 1'b1;
      end else if (kill_i) begin
        done = 1'b1;
      end else if (cyc >= 60) begin
        abort_run($sformatf("vector %0d was not accepted within 60 cycles", idx));
      end
      cyc++;
    end
    idle_inputs();
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'hcc055f6f));
    idle_inputs();
    rst_n      = 1'b0;
    wb_ready_i = 1'b1;
    load_vectors();
    if (vecs.size() == 0) begin
      abort_run("test data holds no vectors");
    end
    // Watchdog allows 40 cycles per vector plus 20 cycles of 8 ns
    fork
      begin
        #((vecs.size() * 40 + 20) * 8);
        abort_run("timeout, the run took longer than its cycle budget");
      end
    join_none
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    compare_flag("wb_valid_o", wb_valid_o, 1'b0);
    compare_flag("wb_rf_we_o", wb_rf_we_o, 1'b0);
    compare_flag("wb_bch_taken_o", wb_bch_taken_o, 1'b0);
    foreach (vecs[i]) begin
      run_instr(vecs[i], i);
    end
    repeat (2) @(posedge clk);
    #1;
    if (u_ex_stage.u_chk.fail_cnt == 0) begin
      $display("TEST PASS");
      $finish;
    end else begin
      $display("%0d checker assertions failed", u_ex_stage.u_chk.fail_cnt);
      end_with_failure();
    end
  end

  // Stop at the first assertion failure in the bound checker
  initial begin
    wait (u_ex_stage.u_chk.fail_cnt != 0);
    abort_run("an assertion in the bound checker failed");
  end

endmodule

`default_nettype wire

// ==== bench/ex_stage_chk.sv ====
// Concurrent assertions on the execute stage handshake and EX/WB register, bound into ex_stage
`default_nettype none

module ex_stage_chk import ex_pkg::*; (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  valid_i,
  input logic                  alu_en_i,
  input logic                  mul_en_i,
  input logic                  div_en_i,
  input logic                  kill_i,
  input logic                  halt_i,
  input logic                  wb_ready_i,
  input logic                  ex_valid_o,
  input logic                  wb_valid_o,
  input logic                  wb_rf_we_o,
  input logic [REG_ADDR_W-1:0] wb_rf_waddr_o,
  input logic [XLEN-1:0]       wb_rf_wdata_o,
  input logic                  wb_bch_taken_o
);

  timeunit 1ns;
  timeprecision 100ps;

  // Number of failed assertions so far
  int fail_cnt = 0;

  // Kill and halt hide the instruction from write-back
  a_no_valid_on_kill_halt: assert property (@(posedge clk) disable iff (!rst_n)
    (kill_i || halt_i) |-> !ex_valid_o)
  else begin
    fail_cnt++;
    $error("ex_valid_o high while kill_i or halt_i is high");
  end

  // EX/WB control holds through a stall
  a_wb_ctrl_hold: assert property (@(posedge clk) disable iff (!rst_n)
    !wb_ready_i |=> $stable(wb_valid_o) && $stable(wb_rf_we_o) && $stable(wb_bch_taken_o))
  else begin
    fail_cnt++;
    $error("write-back control changed while wb_ready_i was low");
  end

  // Payload is defined once a register write was handed over
  a_wb_data_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (!wb_ready_i && wb_rf_we_o) |=> $stable(wb_rf_waddr_o) && $stable(wb_rf_wdata_o))
  else begin
    fail_cnt++;
    $error("write-back address or data changed while wb_ready_i was low");
  end

  a_one_unit: assert property (@(posedge clk) disable iff (!rst_n)
    valid_i |-> $onehot({alu_en_i, mul_en_i, div_en_i}))
  else begin
    fail_cnt++;
    $error("unit enables not one-hot with valid_i high");
  end

  // First clock after reset release
  a_idle_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !wb_valid_o)
  else begin
    fail_cnt++;
    $error("wb_valid_o high in the first cycle after reset");
  end

endmodule

`default_nettype wire

// ==== source/ex_stage.sv ====
// Execute stage top with ALU, multiplier and divider, write-back select and EX/WB register
`default_nettype none

module ex_stage import ex_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,

  // Decoded instruction
  input  logic                  valid_i,
  input  logic                  alu_en_i,
  input  logic                  mul_en_i,
  input  logic                  div_en_i,
  input  alu_op_e               alu_op_i,
  input  mul_op_e               mul_op_i,
  input  div_op_e               div_op_i,
  input  logic [XLEN-1:0]       operand_a_i,
  input  logic [XLEN-1:0]       operand_b_i,
  input  logic                  branch_i,
  input  logic                  rf_we_i,
  input  logic [REG_ADDR_W-1:0] rf_waddr_i,

  // Pipeline control
  input  logic                  kill_i,
  input  logic                  halt_i,
  input  logic                  wb_ready_i,

  output logic                  ex_ready_o,
  output logic                  ex_valid_o,
  output logic                  branch_decision_o,

  // EX/WB register
  output logic                  wb_valid_o,
  output logic                  wb_rf_we_o,
  output logic [REG_ADDR_W-1:0] wb_rf_waddr_o,
  output logic [XLEN-1:0]       wb_rf_wdata_o,
  output logic                  wb_bch_taken_o
);

  logic            instr_valid;
  logic            mul_en_gated;
  logic            div_en_gated;
  logic            alu_ready;
  logic            mul_valid;
  logic            mul_ready;
  logic            div_valid;
  logic            div_ready;
  logic [XLEN-1:0] alu_result;
  logic            alu_cmp_result;
  logic [XLEN-1:0] mul_result;
  logic [XLEN-1:0] div_result;
  logic [XLEN-1:0] rf_wdata;

  div_alu_if div_alu ();

  // Kill and halt both hide the instruction from the units
  assign instr_valid  = valid_i && !kill_i && !halt_i;
  assign mul_en_gated = mul_en_i && instr_valid;
  assign div_en_gated = div_en_i && instr_valid;

  //////////////////////////////////////////////////////////////////////
  // Units
  //////////////////////////////////////////////////////////////////////

  ex_alu u_alu (
    .operator_i   (alu_op_i),
    .operand_a_i  (operand_a_i),
    .operand_b_i  (operand_b_i),
    .div_if       (div_alu.alu),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp_result)
  );

  // ALU is combinational and ready whenever write-back is
  assign alu_ready = wb_ready_i;

  ex_mult u_mult (
    .clk        (clk),
    .rst_n      (rst_n),
    .operator_i (mul_op_i),
    .op_a_i     (operand_a_i),
    .op_b_i     (operand_b_i),
    .valid_i    (mul_en_gated),
    .ready_i    (wb_ready_i),
    .ready_o    (mul_ready),
    .valid_o    (mul_valid),
    .result_o   (mul_result)
  );

  ex_div u_div (
    .clk        (clk),
    .rst_n      (rst_n),
    .operator_i (div_op_i),
    .op_a_i     (operand_a_i),
    .op_b_i     (operand_b_i),
    .valid_i    (div_en_gated),
    .ready_i    (wb_ready_i),
    .div_if     (div_alu.div),
    .ready_o    (div_ready),
    .valid_o    (div_valid),
    .result_o   (div_result)
  );

  //////////////////////////////////////////////////////////////////////
  // Stage handshake, write data and branch
  //////////////////////////////////////////////////////////////////////

  // ALU result is valid in the same cycle
  assign ex_valid_o = (alu_en_i ||
                       (mul_en_i && mul_valid) ||
                       (div_en_i && div_valid)) && instr_valid;

  // Killed instruction leaves at once
  assign ex_ready_o = kill_i || (alu_ready && mul_ready && div_ready && !halt_i);

  // Write data from the enabled unit
  always_comb begin
    unique case (1'b1)
      mul_en_i: rf_wdata = mul_result;
      div_en_i: rf_wdata = div_result;
      default:  rf_wdata = alu_result;
    endcase
  end

  assign branch_decision_o = alu_cmp_result && branch_i && alu_en_i;

  // EX/WB control
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_valid_o     <= 1'b0;
      wb_rf_we_o     <= 1'b0;
      wb_bch_taken_o <= 1'b0;
    end else if (ex_valid_o && wb_ready_i) begin
      wb_valid_o     <= 1'b1;
      wb_rf_we_o     <= rf_we_i;
      wb_bch_taken_o <= branch_i && branch_decision_o;
    end else if (wb_ready_i) begin
      // No instruction to hand over gives a bubble
      wb_valid_o <= 1'b0;
    end
  end

  // EX/WB payload is written only for register writes
  always_ff @(posedge clk) begin
    if (ex_valid_o && wb_ready_i && rf_we_i) begin
      wb_rf_waddr_o <= rf_waddr_i;
      wb_rf_wdata_o <= rf_wdata;
    end
  end

endmodule

`default_nettype wire

// ==== source/ex_div.sv ====
// Iterative restoring divider for DIV, DIVU, REM and REMU using the ALU counter and shifter
`default_nettype none

module ex_div import ex_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,

  input  div_op_e         operator_i,
  input  logic [XLEN-1:0] op_a_i,
  input  logic [XLEN-1:0] op_b_i,

  // Handshakes
  input  logic            valid_i,
  input  logic            ready_i,

  // Requests to the ALU
  div_alu_if.div          div_if,

  output logic            ready_o,
  output logic            valid_o,
  output logic [XLEN-1:0] result_o
);

  typedef enum logic [1:0] {
    DIV_IDLE,
    DIV_ALIGN,
    DIV_ITER,
    DIV_DONE
  } div_state_e;

  div_state_e         state_q;
  logic [SHAMT_W-1:0] cnt_q;
  logic               is_signed;
  logic               a_neg;
  logic               b_neg;
  logic [XLEN-1:0]    a_abs;
  logic [XLEN-1:0]    b_abs;
  logic [XLEN-1:0]    b_abs_q;
  logic               b_neg_q;
  logic [XLEN-1:0]    b_rev;
  logic [XLEN-1:0]    dvsr_aligned;
  logic [XLEN-1:0]    dvsr_q;
  logic [XLEN-1:0]    rem_q;
  logic [XLEN-1:0]    quot_q;
  logic               quot_neg_q;
  logic               rem_neg_q;
  logic               rem_sel_q;
  logic [XLEN:0]      rem_diff;
  logic               rem_ge;

  // Operand magnitudes at start
  assign is_signed = (operator_i == DIV) || (operator_i == REM);
  assign a_neg     = is_signed && op_a_i[XLEN-1];
  assign b_neg     = is_signed && op_b_i[XLEN-1];
  assign a_abs     = a_neg ? -op_a_i : op_a_i;
  assign b_abs     = b_neg ? -op_b_i : op_b_i;

  always_comb begin
    for (int i = 0; i < XLEN; i++) begin
      b_rev[i] = b_abs_q[XLEN-1-i];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // ALU requests, only in the align cycle
  //////////////////////////////////////////////////////////////////////

  assign div_if.clz_en       = (state_q == DIV_ALIGN);
  assign div_if.clz_data_rev = b_rev;
  assign div_if.shift_en     = (state_q == DIV_ALIGN);
  assign div_if.shift_amt    = div_if.clz_result;

  // ALU shifts the raw divisor, magnitude taken after the shift
  assign dvsr_aligned = b_neg_q ? -div_if.op_b_shifted : div_if.op_b_shifted;

  // Restoring step
  assign rem_diff = {1'b0, rem_q} - {1'b0, dvsr_q};
  assign rem_ge   = !rem_diff[XLEN];

  // Control FSM, any drop of valid_i abandons the division
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= DIV_IDLE;
      cnt_q   <= '0;
    end else if (!valid_i) begin
      state_q <= DIV_IDLE;
    end else begin
      unique case (state_q)
        DIV_IDLE:  state_q <= DIV_ALIGN;
        DIV_ALIGN: begin
          // Zero divisor skips the iterations
          state_q <= (b_abs_q == '0) ? DIV_DONE : DIV_ITER;
          cnt_q   <= div_if.clz_result;
        end
        DIV_ITER: begin
          if (cnt_q == '0) begin
            state_q <= DIV_DONE;
          end
          cnt_q <= cnt_q - 1'b1;
        end
        DIV_DONE:  state_q <= ready_i ? DIV_IDLE : DIV_DONE;
        default:   state_q <= DIV_IDLE;
      endcase
    end
  end

  // Datapath
  always_ff @(posedge clk) begin
    if (valid_i) begin
      unique case (state_q)
        DIV_IDLE: begin
          rem_q      <= a_abs;
          quot_q     <= '0;
          b_abs_q    <= b_abs;
          b_neg_q    <= b_neg;
          quot_neg_q <= a_neg ^ b_neg;
          rem_neg_q  <= a_neg;
          rem_sel_q  <= (operator_i == REM) || (operator_i == REMU);
        end
        DIV_ALIGN: begin
          dvsr_q <= dvsr_aligned;
          // Division by zero, quotient all ones and remainder keeps the dividend
          if (b_abs_q == '0) begin
            quot_q     <= '1;
            quot_neg_q <= 1'b0;
          end
        end
        DIV_ITER: begin
          if (rem_ge) begin
            rem_q <= rem_diff[XLEN-1:0];
          end
          quot_q <= {quot_q[XLEN-2:0], rem_ge};
          dvsr_q <= dvsr_q >> 1;
        end
        default: ;
      endcase
    end
  end

  // Sign fix, the overflow case falls out of the magnitudes
  assign result_o = rem_sel_q ? (rem_neg_q ? -rem_q : rem_q)
                              : (quot_neg_q ? -quot_q : quot_q);

  assign ready_o = (state_q == DIV_IDLE) || ((state_q == DIV_DONE) && ready_i);
  assign valid_o = (state_q == DIV_DONE) && valid_i;

endmodule

`default_nettype wire

// ==== source/ex_mult.sv ====
// One-cycle registered multiplier for MUL, MULH, MULHSU and MULHU with valid/ready hold
`default_nettype none

module ex_mult import ex_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,

  input  mul_op_e         operator_i,
  input  logic [XLEN-1:0] op_a_i,
  input  logic [XLEN-1:0] op_b_i,

  // Handshakes
  input  logic            valid_i,
  input  logic            ready_i,
  output logic            ready_o,
  output logic            valid_o,

  output logic [XLEN-1:0] result_o
);

  logic                     sign_a;
  logic                     sign_b;
  logic signed [XLEN:0]     op_a_ext;
  logic signed [XLEN:0]     op_b_ext;
  logic signed [PROD_W-1:0] prod_d;
  logic signed [PROD_W-1:0] prod_q;
  logic                     hi_sel_q;
  logic                     valid_q;

  // Operand signedness per operator, MUL low word does not care
  assign sign_a = (operator_i != MULHU);
  assign sign_b = (operator_i == MUL) || (operator_i == MULH);

  assign op_a_ext = {sign_a & op_a_i[XLEN-1], op_a_i};
  assign op_b_ext = {sign_b & op_b_i[XLEN-1], op_b_i};
  assign prod_d   = op_a_ext * op_b_ext;

  // Result pending flag
  // Cleared on acceptance, or when the instruction goes away (kill or halt)
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (!valid_i) begin
      valid_q <= 1'b0;
    end else if (!valid_q) begin
      valid_q <= 1'b1;
    end else if (ready_i) begin
      valid_q <= 1'b0;
    end
  end

  // Product captured in the launch cycle only, held after that
  always_ff @(posedge clk) begin
    if (valid_i && !valid_q) begin
      prod_q   <= prod_d;
      hi_sel_q <= (operator_i != MUL);
    end
  end

  assign result_o = hi_sel_q ? prod_q[2*XLEN-1:XLEN] : prod_q[XLEN-1:0];

  // Busy while a result waits for the next stage
  assign ready_o = !valid_q || ready_i;
  assign valid_o = valid_q && valid_i;

endmodule

`default_nettype wire

// ==== source/ex_alu.sv ====
// Single-cycle ALU with branch compare; also serves the divider's count and shift requests
`default_nettype none

module ex_alu import ex_pkg::*; (
  input  alu_op_e         operator_i,
  input  logic [XLEN-1:0] operand_a_i,
  input  logic [XLEN-1:0] operand_b_i,

  // Shared counter and shifter for the divider
  div_alu_if.alu          div_if,

  output logic [XLEN-1:0] result_o,
  output logic            cmp_result_o
);

  logic               is_sub;
  logic [XLEN-1:0]    add_result;
  logic               eq;
  logic               lt_s;
  logic               lt_u;
  logic [XLEN-1:0]    shift_in;
  logic [SHAMT_W-1:0] shift_amt;
  logic [XLEN-1:0]    shift_left;
  logic [XLEN-1:0]    shift_right_l;
  logic [XLEN-1:0]    shift_right_a;
  logic [SHAMT_W-1:0] tz_count;

  //////////////////////////////////////////////////////////////////////
  // Adder and comparator
  //////////////////////////////////////////////////////////////////////

  // Subtract as invert plus carry in
  assign is_sub     = (operator_i == SUB);
  assign add_result = operand_a_i + (operand_b_i ^ {XLEN{is_sub}}) + XLEN'(is_sub);

  assign eq   = (operand_a_i == operand_b_i);
  assign lt_s = ($signed(operand_a_i) < $signed(operand_b_i));
  assign lt_u = (operand_a_i < operand_b_i);

  always_comb begin
    unique case (operator_i)
      EQ, NE:    cmp_result_o = (operator_i == EQ) ? eq : !eq;
      LT, SLT:   cmp_result_o = lt_s;
      GE:        cmp_result_o = !lt_s;
      LTU, SLTU: cmp_result_o = lt_u;
      GEU:       cmp_result_o = !lt_u;
      default:   cmp_result_o = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Shifter, left path shared with the divider
  //////////////////////////////////////////////////////////////////////

  // Divider takes over the left shifter to align its divisor
  assign shift_in  = div_if.shift_en ? operand_b_i : operand_a_i;
  assign shift_amt = div_if.shift_en ? div_if.shift_amt : {1'b0, operand_b_i[SHAMT_W-2:0]};

  assign shift_left          = shift_in << shift_amt;
  assign div_if.op_b_shifted = shift_left;

  assign shift_right_l = operand_a_i >> operand_b_i[SHAMT_W-2:0];
  assign shift_right_a = $unsigned($signed(operand_a_i) >>> operand_b_i[SHAMT_W-2:0]);

  // Trailing zeros of the reversed word, i.e. leading zeros of the original
  // All zero input gives XLEN
  always_comb begin
    tz_count = SHAMT_W'(XLEN);
    for (int i = XLEN - 1; i >= 0; i--) begin
      if (div_if.clz_data_rev[i]) begin
        tz_count = SHAMT_W'(i);
      end
    end
  end

  assign div_if.clz_result = div_if.clz_en ? tz_count : '0;

  // Result select
  always_comb begin
    unique case (operator_i)
      ADD, SUB: result_o = add_result;
      AND:      result_o = operand_a_i & operand_b_i;
      OR:       result_o = operand_a_i | operand_b_i;
      XOR:      result_o = operand_a_i ^ operand_b_i;
      SLL:      result_o = shift_left;
      SRL:      result_o = shift_right_l;
      SRA:      result_o = shift_right_a;
      default:  result_o = {{(XLEN-1){1'b0}}, cmp_result_o}; // set-less-than and compares
    endcase
  end

endmodule

`default_nettype wire

// ==== source/div_alu_if.sv ====
// Divider to ALU request path for the shared leading-zero counter and left shifter
`default_nettype none

interface div_alu_if import ex_pkg::*; ();

  // Leading-zero request, data is bit reversed by the divider
  logic               clz_en;
  logic [XLEN-1:0]    clz_data_rev;
  logic [SHAMT_W-1:0] clz_result;

  // Left shift request on the divisor operand
  logic               shift_en;
  logic [SHAMT_W-1:0] shift_amt;
  logic [XLEN-1:0]    op_b_shifted;

  // Divider side issues the requests
  modport div (
    output clz_en,
    output clz_data_rev,
    output shift_en,
    output shift_amt,
    input  clz_result,
    input  op_b_shifted
  );

  // ALU side answers in the same cycle
  modport alu (
    input  clz_en,
    input  clz_data_rev,
    input  shift_en,
    input  shift_amt,
    output clz_result,
    output op_b_shifted
  );

endinterface

`default_nettype wire

// ==== source/ex_pkg.sv ====
// Widths and operator encodings of the execute stage; import with ex_pkg::* where needed
`default_nettype none

package ex_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  // Data word
  localparam int unsigned XLEN       = 32;
  // Register file address
  localparam int unsigned REG_ADDR_W = 5;
  // Shift amount and leading-zero count, wide enough to hold XLEN itself
  localparam int unsigned SHAMT_W    = 6;
  // Full signed product of two sign-extended XLEN+1 bit operands
  localparam int unsigned PROD_W     = 2 * XLEN + 1;

  //////////////////////////////////////////////////////////////////////
  // Operator encodings
  //////////////////////////////////////////////////////////////////////

  // ALU operators
  // EQ to GEU are the branch compares, SLT and SLTU also drive the compare
  typedef enum logic [3:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    SLL,
    SRL,
    SRA,
    SLT,
    SLTU,
    EQ,
    NE,
    LT,
    GE,
    LTU,
    GEU
  } alu_op_e;

  // Multiplier operators
  typedef enum logic [1:0] {
    MUL,
    MULH,
    MULHSU,
    MULHU
  } mul_op_e;

  // Divider operators
  typedef enum logic [1:0] {
    DIV,
    DIVU,
    REM,
    REMU
  } div_op_e;

endpackage

`default_nettype wire
